// ==== fb_pkg.sv ====
package fb_pkg;

    typedef logic [3:0] color_t;       // palette index
    typedef logic [2:0] brush_size_t;  // size switch, radius = 2*size + 1
    typedef logic [7:0] byte_t;        // one byte of the save stream

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;                           // 24 bits, red in the top byte

    localparam rgb_t PALETTE_BLACK   = 24'h00_00_00;  // index 0
    localparam rgb_t PALETTE_WHITE   = 24'hff_ff_ff;  // index 1 and all unused indices
    localparam rgb_t PALETTE_RED     = 24'hff_00_00;  // index 2
    localparam rgb_t PALETTE_GREEN   = 24'h00_ff_00;  // index 3
    localparam rgb_t PALETTE_BLUE    = 24'h00_00_ff;  // index 4
    localparam rgb_t PALETTE_CYAN    = 24'h00_ff_ff;  // index 5
    localparam rgb_t PALETTE_MAGENTA = 24'hff_00_ff;  // index 6
    localparam rgb_t PALETTE_YELLOW  = 24'hff_ff_00;  // index 7
    localparam rgb_t PALETTE_GRAY    = 24'h80_80_80;  // index 8

endpackage

// ==== pixel_if.sv ====
`timescale 1ns/10ps

interface pixel_if import fb_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 360
) ();

    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);  // one word per pixel

    logic [ADDR_W-1:0] addr;    // pixel under the scan, also the display read address
    color_t            color1;  // brush 1 color, port A
    logic              we1;     // brush 1 hit while drawing
    color_t            color2;  // brush 2 color, port B
    logic              we2;     // brush 2 hit while drawing

    modport stage (
        output addr,
        output color1,
        output we1,
        output color2,
        output we2
    );

    modport store (
        input addr,
        input color1,
        input we1,
        input color2,
        input we2
    );

endinterface

// ==== brush_stage.sv ====
`timescale 1ns/10ps

module brush_stage import fb_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 360,
    localparam int HW = $clog2(H_ACTIVE),
    localparam int VW = $clog2(V_ACTIVE)
) (
    input  logic          clk_25mhz,
    input  logic          reset_SD_card,
    input  logic [HW-1:0] hcount_in,
    input  logic [VW-1:0] vcount_in,
    input  logic [HW-1:0] x_in1,
    input  logic [VW-1:0] y_in1,
    input  logic [HW-1:0] x_in2,
    input  logic [VW-1:0] y_in2,
    input  color_t        color_in1,
    input  color_t        color_in2,
    input  brush_size_t   sw_in1,
    input  brush_size_t   sw_in2,
    input  logic          draw,
    pixel_if.stage        pix
);

    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);
    localparam int DW     = ((HW > VW) ? HW : VW) + 1;  // one spare bit for the sign
    localparam int SW     = 2 * DW + 1;                 // squared terms and their sum

    logic signed [DW-1:0]   h_s, v_s;          // scan position, signed
    logic signed [DW-1:0]   dx1, dy1, dx2, dy2;
    logic signed [2*DW:0]   dist1, dist2;      // squared distance to each center
    logic        [3:0]      r1, r2;            // radius, always odd
    logic signed [2*DW:0]   r1_sq, r2_sq;
    logic                   hit1, hit2;
    logic [ADDR_W-1:0]      addr_next;

    assign h_s = $signed(DW'(hcount_in));  // zero extend before going signed
    assign v_s = $signed(DW'(vcount_in));

    assign dx1 = h_s - $signed(DW'(x_in1));
    assign dy1 = v_s - $signed(DW'(y_in1));
    assign dx2 = h_s - $signed(DW'(x_in2));
    assign dy2 = v_s - $signed(DW'(y_in2));

    assign dist1 = SW'(dx1) * SW'(dx1) + SW'(dy1) * SW'(dy1);  // sign extended first
    assign dist2 = SW'(dx2) * SW'(dx2) + SW'(dy2) * SW'(dy2);

    assign r1    = {sw_in1, 1'b1};  // 2*size + 1
    assign r2    = {sw_in2, 1'b1};
    assign r1_sq = $signed(SW'(r1)) * $signed(SW'(r1));
    assign r2_sq = $signed(SW'(r2)) * $signed(SW'(r2));

    assign hit1 = (dist1 <= r1_sq);  // edge of the circle counts as inside
    assign hit2 = (dist2 <= r2_sq);

    assign addr_next = ADDR_W'(vcount_in) * ADDR_W'(H_ACTIVE) + ADDR_W'(hcount_in);  // raster order

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            pix.we1 <= 1'b0;  // no write pending after reset
            pix.we2 <= 1'b0;
        end else begin
            pix.we1 <= hit1 && draw;
            pix.we2 <= hit2 && draw;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        pix.addr   <= addr_next;
        pix.color1 <= color_in1;
        pix.color2 <= color_in2;
    end

endmodule

// ==== frame_store.sv ====
`timescale 1ns/10ps

module frame_store import fb_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 360,
    localparam int FRAME  = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W = $clog2(FRAME)
) (
    input  logic              clk_25mhz,
    pixel_if.store            pix,
    input  logic              save_active,
    input  logic [ADDR_W-1:0] save_addr,
    output color_t            save_pixel,
    output color_t            disp_pixel
);

    color_t            mem [FRAME];  // one palette index per pixel
    logic [ADDR_W-1:0] addr_a;       // port A address, brush or saver
    logic              we_a;
    logic              we_b;

    initial begin
        for (int i = 0; i < FRAME; i++) begin
            mem[i] = '0;  // power up black like a block RAM init
        end
    end

    assign addr_a = save_active ? save_addr : pix.addr;  // saver owns port A
    assign we_a   = pix.we1 && !save_active;             // frame is frozen during a save
    assign we_b   = pix.we2 && !save_active;

    always_ff @(posedge clk_25mhz) begin
        save_pixel <= mem[addr_a];    // read-first, old contents
        disp_pixel <= mem[pix.addr];  // display port, read-first
        if (we_a) begin
            mem[addr_a] <= pix.color1;
        end
        if (we_b) begin
            mem[pix.addr] <= pix.color2;  // later write, brush 2 wins
        end
    end

endmodule

// ==== palette_stage.sv ====
`timescale 1ns/10ps

module palette_stage import fb_pkg::*; (
    input  logic   clk_25mhz,
    input  logic   reset_SD_card,
    input  color_t disp_pixel,
    output rgb_t   rgb
);

    rgb_t rgb_next;

    always_comb begin
        case (disp_pixel)
            4'd0:    rgb_next = PALETTE_BLACK;
            4'd1:    rgb_next = PALETTE_WHITE;
            4'd2:    rgb_next = PALETTE_RED;
            4'd3:    rgb_next = PALETTE_GREEN;
            4'd4:    rgb_next = PALETTE_BLUE;
            4'd5:    rgb_next = PALETTE_CYAN;
            4'd6:    rgb_next = PALETTE_MAGENTA;
            4'd7:    rgb_next = PALETTE_YELLOW;
            4'd8:    rgb_next = PALETTE_GRAY;
            default: rgb_next = PALETTE_WHITE;  // unused indices show white
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            rgb <= PALETTE_BLACK;  // screen black out of reset
        end else begin
            rgb <= rgb_next;
        end
    end

endmodule

// ==== image_saver.sv ====
`timescale 1ns/10ps

module image_saver import fb_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 360,
    localparam int FRAME  = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W = $clog2(FRAME)
) (
    input  logic              clk_25mhz,
    input  logic              reset_SD_card,
    input  logic              draw,
    output logic              save_active,
    output logic [ADDR_W-1:0] save_addr,
    input  color_t            save_pixel,
    output logic              save_req,
    input  logic              save_ack,
    output byte_t             save_data,
    output logic              save_busy
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME - 1);

    typedef enum logic [1:0] {
        IDLE,       // waiting for draw to fall
        READ_WAIT,  // memory read in flight
        REQUEST,    // raise req, then wait for ack
        ACK_LOW     // wait for the agent to drop ack
    } state_t;

    state_t state;
    logic   draw_d;  // last draw, for the falling edge

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            state       <= IDLE;
            draw_d      <= 1'b0;
            save_addr   <= '0;
            save_active <= 1'b0;
            save_req    <= 1'b0;
            save_busy   <= 1'b0;
        end else begin
            draw_d <= draw;
            case (state)
                IDLE: begin
                    if (draw_d && !draw) begin  // drawing just ended
                        save_addr   <= '0;
                        save_active <= 1'b1;    // freeze the frame, take port A
                        save_busy   <= 1'b1;
                        state       <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    state <= REQUEST;  // data for save_addr lands this edge
                end
                REQUEST: begin
                    if (!save_req) begin
                        save_data <= {4'h0, save_pixel};  // upper nibble zero
                        save_req  <= 1'b1;
                    end else if (save_ack) begin
                        save_req <= 1'b0;                 // data may change after this
                        state    <= ACK_LOW;
                    end
                end
                ACK_LOW: begin
                    if (!save_ack) begin  // four-phase done for this byte
                        if (save_addr == LAST_ADDR) begin
                            save_active <= 1'b0;
                            save_busy   <= 1'b0;
                            state       <= IDLE;
                        end else begin
                            save_addr <= save_addr + ADDR_W'(1);
                            state     <= READ_WAIT;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== paint_top.sv ====
`timescale 1ns/10ps

module paint_top import fb_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 360,
    localparam int HW = $clog2(H_ACTIVE),
    localparam int VW = $clog2(V_ACTIVE)
) (
    input  logic          clk_25mhz,
    input  logic          reset_SD_card,
    input  logic [HW-1:0] hcount_in,
    input  logic [VW-1:0] vcount_in,
    input  logic [HW-1:0] x_in1,
    input  logic [VW-1:0] y_in1,
    input  logic [HW-1:0] x_in2,
    input  logic [VW-1:0] y_in2,
    input  color_t        color_in1,
    input  color_t        color_in2,
    input  brush_size_t   sw_in1,
    input  brush_size_t   sw_in2,
    input  logic          draw,
    input  logic          save_ack,
    output logic          save_req,
    output byte_t         save_data,
    output logic          save_busy,
    output logic [7:0]    red_out,
    output logic [7:0]    green_out,
    output logic [7:0]    blue_out
);

    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);

    logic              save_active;  // saver holds memory port A
    logic [ADDR_W-1:0] save_addr;
    color_t            save_pixel;
    color_t            disp_pixel;   // stage 2 to stage 3
    rgb_t              rgb;

    pixel_if #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) pix ();  // stage 1 to stage 2

    brush_stage #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_brush (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .hcount_in     (hcount_in),
        .vcount_in     (vcount_in),
        .x_in1         (x_in1),
        .y_in1         (y_in1),
        .x_in2         (x_in2),
        .y_in2         (y_in2),
        .color_in1     (color_in1),
        .color_in2     (color_in2),
        .sw_in1        (sw_in1),
        .sw_in2        (sw_in2),
        .draw          (draw),
        .pix           (pix.stage)
    );

    frame_store #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_store (
        .clk_25mhz   (clk_25mhz),
        .pix         (pix.store),
        .save_active (save_active),
        .save_addr   (save_addr),
        .save_pixel  (save_pixel),
        .disp_pixel  (disp_pixel)
    );

    palette_stage u_palette (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .disp_pixel    (disp_pixel),
        .rgb           (rgb)
    );

    image_saver #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_saver (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .draw          (draw),
        .save_active   (save_active),
        .save_addr     (save_addr),
        .save_pixel    (save_pixel),
        .save_req      (save_req),
        .save_ack      (save_ack),
        .save_data     (save_data),
        .save_busy     (save_busy)
    );

    assign red_out   = rgb.red;    // 3 cycles after hcount/vcount
    assign green_out = rgb.green;
    assign blue_out  = rgb.blue;

endmodule

// ==== tb_paint_assert.sv ====
`timescale 1ns/10ps

module tb_paint_assert import fb_pkg::*; (
    input logic  clk_25mhz,
    input logic  reset_SD_card,
    input logic  save_req,
    input logic  save_ack,
    input byte_t save_data,
    input logic  save_busy
);

    // req waits for the agent
    req_held: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        save_req && !save_ack |=> save_req)
        else $error("save_req dropped before save_ack");

    data_stable: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        save_req |=> $stable(save_data))  // byte may change only while req is low
        else $error("save_data changed while save_req was high");

    req_only_when_busy: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        !save_busy |-> !save_req)
        else $error("save_req high while the saver is idle");

endmodule

bind image_saver tb_paint_assert u_handshake_check (
    .clk_25mhz     (clk_25mhz),
    .reset_SD_card (reset_SD_card),
    .save_req      (save_req),
    .save_ack      (save_ack),
    .save_data     (save_data),
    .save_busy     (save_busy)
);

// ==== tb_paint.sv ====
`timescale 1ns/10ps

module tb_paint import fb_pkg::*; ();

    localparam int H = 32;
    localparam int V = 16;
    localparam int FRAME = H * V;
    localparam int LIMIT = 5 * FRAME * 16 + 10 * (FRAME + 4) + 2000;  // saves, sweeps, slack

    logic        clk_25mhz = 1'b0;
    logic        reset_SD_card;
    logic [4:0]  hcount_in, x_in1, x_in2;
    logic [3:0]  vcount_in, y_in1, y_in2;
    color_t      color_in1, color_in2;
    brush_size_t sw_in1, sw_in2;
    logic        draw;
    logic        save_ack = 1'b0;  // owned by the storage agent
    logic        save_req, save_busy;
    byte_t       save_data;
    logic [7:0]  red_out, green_out, blue_out;

    color_t      model [FRAME];    // expected frame contents
    byte_t       received [$];     // every byte the agent accepted
    int          save_start;       // queue index where the current save begins
    integer      seed = 32'h44b52816;
    int          cycles = 0;

    paint_top #(.H_ACTIVE(H), .V_ACTIVE(V)) dut (.*);

    always #20 clk_25mhz = ~clk_25mhz;  // 25 MHz

    always @(posedge clk_25mhz) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("ERRORS FOUND");
            $fatal(1, "timeout, the run did not finish within %0d cycles", LIMIT);
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [23:0] expected_rgb(input color_t c);
        case (c)
            4'd0:    return 24'h000000;
            4'd1:    return 24'hffffff;
            4'd2:    return 24'hff0000;
            4'd3:    return 24'h00ff00;
            4'd4:    return 24'h0000ff;
            4'd5:    return 24'h00ffff;
            4'd6:    return 24'hff00ff;
            4'd7:    return 24'hffff00;
            4'd8:    return 24'h808080;
            default: return 24'hffffff;  // unused indices
        endcase
    endfunction

    function automatic bit brush_covers(input int h, input int v, input int x, input int y,
                                        input int size);
        int r;
        r = 2 * size + 1;
        return (h - x) * (h - x) + (v - y) * (v - y) <= r * r;  // rim included
    endfunction

    function automatic void apply_brushes(input int h, input int v);
        if (brush_covers(h, v, int'(x_in1), int'(y_in1), int'(sw_in1))) begin
            model[v * H + h] = color_in1;
        end
        if (brush_covers(h, v, int'(x_in2), int'(y_in2), int'(sw_in2))) begin
            model[v * H + h] = color_in2;  // brush 2 on top
        end
    endfunction

    // storage agent serving one byte per call with random ack timing
    task automatic serve_byte();
        int delay;
        @(negedge clk_25mhz);
        while (save_req !== 1'b1) begin
            @(negedge clk_25mhz);
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_25mhz);
        received.push_back(save_data);  // data is stable while req is up
        save_ack = 1'b1;
        while (save_req !== 1'b0) begin
            @(negedge clk_25mhz);
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_25mhz);
        save_ack = 1'b0;
    endtask

    always begin
        serve_byte();
    end

    task automatic set_brushes(input int x1, input int y1, input int s1, input int c1,
                               input int x2, input int y2, input int s2, input int c2);
        @(negedge clk_25mhz);
        x_in1 = 5'(x1);
        y_in1 = 4'(y1);
        sw_in1 = 3'(s1);
        color_in1 = 4'(c1);
        x_in2 = 5'(x2);
        y_in2 = 4'(y2);
        sw_in2 = 3'(s2);
        color_in2 = 4'(c2);
        if (draw) begin
            apply_brushes(int'(hcount_in), int'(vcount_in));  // current pixel gets repainted
        end
    endtask

    task automatic start_drawing();
        @(negedge clk_25mhz);
        draw = 1'b1;
        apply_brushes(int'(hcount_in), int'(vcount_in));
    endtask

    // paint mode updates the model while check mode compares rgb 3 cycles later
    task automatic sweep(input int x0, input int y0, input int w, input int ht, input bit paint);
        int pending [$];
        int idx;
        for (int v = y0; v < y0 + ht; v++) begin
            for (int h = x0; h < x0 + w; h++) begin
                @(negedge clk_25mhz);
                if (pending.size() == 3) begin
                    idx = pending.pop_front();
                    check_equal(32'({red_out, green_out, blue_out}),
                                32'(expected_rgb(model[idx])),
                                $sformatf("rgb of pixel %0d", idx));
                end
                hcount_in = 5'(h);
                vcount_in = 4'(v);
                if (paint) begin
                    apply_brushes(h, v);
                end else begin
                    pending.push_back(v * H + h);
                end
            end
        end
        while (pending.size() > 0) begin  // drain the pipeline
            @(negedge clk_25mhz);
            idx = pending.pop_front();
            check_equal(32'({red_out, green_out, blue_out}), 32'(expected_rgb(model[idx])),
                        $sformatf("rgb of pixel %0d", idx));
        end
    endtask

    task automatic check_pixel(input int h, input int v, input logic [23:0] exp);
        @(negedge clk_25mhz);
        hcount_in = 5'(h);
        vcount_in = 4'(v);
        repeat (3) @(negedge clk_25mhz);  // pipeline latency
        check_equal(32'({red_out, green_out, blue_out}), 32'(exp),
                    $sformatf("rgb at %0d,%0d", h, v));
    endtask

    task automatic start_save();
        @(negedge clk_25mhz);
        save_start = received.size();
        draw = 1'b0;  // falling edge starts the save
        while (save_busy !== 1'b1) begin
            @(negedge clk_25mhz);
        end
    endtask

    task automatic finish_save();
        while (save_busy !== 1'b0) begin
            @(negedge clk_25mhz);
        end
        check_equal(32'(received.size() - save_start), 32'(FRAME), "number of saved bytes");
        for (int a = 0; a < FRAME; a++) begin
            check_equal(32'(received[save_start + a]), 32'({4'h0, model[a]}),
                        $sformatf("saved byte %0d", a));
        end
        check_equal(32'(save_req), 32'd0, "save_req after the save");
    endtask

    task automatic reset_state();
        check_equal(32'(save_busy), 32'd0, "save_busy after reset");
        check_equal(32'(save_req), 32'd0, "save_req after reset");
        check_pixel(3, 2, 24'h000000);
    endtask

    task automatic palette_spots();
        int c;
        set_brushes(2, 4, 0, 0, 31, 15, 0, 0);  // brush 2 parked in a corner
        start_drawing();
        for (int i = 0; i < 10; i++) begin
            c = (i == 9) ? 12 : i;
            set_brushes(2 + 3 * i, 4, 0, c, 31, 15, 0, 0);
            sweep(1 + 3 * i, 3, 3, 3, 1'b1);  // box around the spot
        end
        start_save();
        finish_save();
        for (int i = 0; i < 10; i++) begin
            c = (i == 9) ? 12 : i;
            check_pixel(2 + 3 * i, 4, expected_rgb(4'(c)));
        end
    endtask

    task automatic brush_circle();
        set_brushes(10, 8, 2, 5, 31, 15, 0, 0);  // radius 5
        start_drawing();
        sweep(0, 0, H, V, 1'b1);
        start_save();
        finish_save();
        sweep(0, 0, H, V, 1'b0);
    endtask

    task automatic overlapping_brushes();
        set_brushes(20, 8, 2, 2, 24, 8, 1, 4);  // overlap around x 21 to 25
        start_drawing();
        sweep(0, 0, H, V, 1'b1);
    endtask

    task automatic frame_save();
        start_save();
        finish_save();
        check_pixel(22, 8, 24'h0000ff);  // shared pixel shows brush 2
        sweep(0, 0, H, V, 1'b0);
    endtask

    task automatic draw_during_save();
        start_drawing();
        start_save();
        set_brushes(5, 5, 3, 7, 12, 10, 3, 6);
        draw = 1'b1;  // frame is frozen while saving
        sweep(0, 0, H, V, 1'b0);
        check_equal(32'(save_busy), 32'd1, "save still running after the sweep");
        draw = 1'b0;
        finish_save();
        sweep(0, 0, H, V, 1'b0);
    endtask

    initial begin
        reset_SD_card = 1'b1;
        draw = 1'b0;
        hcount_in = '0;
        vcount_in = '0;
        x_in1 = '0;
        y_in1 = '0;
        x_in2 = '0;
        y_in2 = '0;
        color_in1 = '0;
        color_in2 = '0;
        sw_in1 = '0;
        sw_in2 = '0;
        save_start = 0;
        for (int a = 0; a < FRAME; a++) begin
            model[a] = '0;  // memory powers up black
        end
        repeat (5) @(negedge clk_25mhz);
        reset_SD_card = 1'b0;
        reset_state();
        palette_spots();
        brush_circle();
        overlapping_brushes();
        frame_save();
        draw_during_save();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== vlog.f ====
fb_pkg.sv
pixel_if.sv
brush_stage.sv
frame_store.sv
palette_stage.sv
image_saver.sv
paint_top.sv
tb_paint_assert.sv
tb_paint.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_paint
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
